// File: compile.f
design/dcache_geom_pkg.sv
design/dcache_fsm_pkg.sv
design/dcache_data_ram.sv
design/dcache_meta.sv
design/dcache_merge.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

// File: design/dcache_ctrl.sv
module dcache_ctrl #(
    parameter  int N_WAYS = 4,
    parameter  int N_SETS = 16,
    localparam int WAY_W  = $clog2(N_WAYS),
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int OFS_W  = dcache_geom_pkg::WORD_OFS_W + dcache_geom_pkg::BYTE_OFS_W,
    localparam int TAG_W  = dcache_geom_pkg::XLEN - IDX_W - OFS_W
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   p_strobe_i,
    input  logic                   p_rw_i,           // 1 for write
    input  dcache_geom_pkg::be_t   p_be_i,
    input  dcache_geom_pkg::addr_t p_addr_i,
    input  dcache_geom_pkg::word_t p_data_i,
    input  logic                   p_flush_i,
    output dcache_geom_pkg::word_t p_data_o,
    output logic                   p_ready_o,
    output logic                   busy_flushing_o,
    output logic                   m_strobe_o,
    output logic                   m_rw_o,
    output dcache_geom_pkg::addr_t m_addr_o,
    output dcache_geom_pkg::line_t m_data_o,
    input  logic                   m_ready_i,
    input  dcache_geom_pkg::line_t m_data_i,
    input  logic                   hit_i,
    input  logic [WAY_W-1:0]       hit_way_i,
    input  logic [WAY_W-1:0]       victim_way_i,
    input  logic                   victim_dirty_i,
    input  logic [TAG_W-1:0]       victim_tag_i,
    input  logic [TAG_W-1:0]       way_tag_i,
    input  logic                   way_dirty_i,
    output logic [IDX_W-1:0]       idx_o,
    output logic [TAG_W-1:0]       tag_o,
    output logic [WAY_W-1:0]       way_o,
    output logic                   fill_o,
    output logic                   mark_dirty_o,
    output logic                   clean_o,
    output logic [N_WAYS-1:0]      ram_we_o,
    output dcache_geom_pkg::line_t ram_wdata_o,
    input  dcache_geom_pkg::line_t ram_rdata_i [N_WAYS],
    input  dcache_geom_pkg::word_t merge_word_i,
    input  dcache_geom_pkg::line_t merge_line_i,
    output dcache_geom_pkg::line_t merge_line_o,
    output logic [dcache_geom_pkg::WORD_OFS_W-1:0] merge_ofs_o,
    output dcache_geom_pkg::be_t   merge_be_o,
    output dcache_geom_pkg::word_t merge_wdata_o
);
    import dcache_geom_pkg::*;
    import dcache_fsm_pkg::*;

    ctrl_state_t      state_q;
    ctrl_state_t      state_d;
    addr_t            req_addr_q;     // Latched processor request
    logic             req_rw_q;
    be_t              req_be_q;
    word_t            req_data_q;
    line_t            fill_line_q;    // Line returned by memory
    logic [IDX_W-1:0] req_idx;
    logic [IDX_W-1:0] set_cnt_q;      // Flush walk position
    logic [WAY_W-1:0] way_cnt_q;
    logic             walk_last;
    logic             walk_done_q;
    logic             flush_step;
    logic             req_sent_q;     // Waiting on m_ready_i
    logic             launch;
    logic             wr_hit;

    assign req_idx    = req_addr_q[OFS_W +: IDX_W];
    assign tag_o      = req_addr_q[XLEN-1 -: TAG_W];
    assign wr_hit     = (state_q == LOOKUP) && !busy_flushing_o && hit_i && req_rw_q;
    assign walk_last  = (set_cnt_q == IDX_W'(N_SETS - 1)) && (way_cnt_q == WAY_W'(N_WAYS - 1));
    assign flush_step = (state_q == FLUSH_REQ) && (!way_dirty_i || m_ready_i);
    assign launch     = !req_sent_q && ((state_q == EVICT_REQ) || (state_q == FILL_REQ) ||
                                        ((state_q == FLUSH_REQ) && way_dirty_i));

    // ==============================
    // State machine
    // ==============================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (p_flush_i || p_strobe_i) state_d = LOOKUP;
            LOOKUP:
            begin
                if (busy_flushing_o)
                    state_d = FLUSH_REQ;
                else if (hit_i)
                    state_d = IDLE;
                else
                    state_d = victim_dirty_i ? EVICT_REQ : FILL_REQ;  // Write back first
            end
            EVICT_REQ:  if (m_ready_i) state_d = EVICT_DONE;
            EVICT_DONE: state_d = FILL_REQ;
            FILL_REQ:   if (m_ready_i) state_d = FILL_DONE;
            FILL_DONE:  state_d = IDLE;
            FLUSH_REQ:  if (flush_step) state_d = FLUSH_DONE;
            FLUSH_DONE: state_d = walk_done_q ? IDLE : FLUSH_REQ;
            default:    state_d = IDLE;
        endcase
    end

    // State, flush flag and walk counters
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q         <= IDLE;
            busy_flushing_o <= 1'b0;
            set_cnt_q       <= '0;
            way_cnt_q       <= '0;
            walk_done_q     <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if ((state_q == IDLE) && p_flush_i)
                busy_flushing_o <= 1'b1;
            else if (flush_step && walk_last)
                busy_flushing_o <= 1'b0;     // Low in the final ready cycle
            if (flush_step)
            begin
                way_cnt_q   <= way_cnt_q + 1'b1;   // Ways inner, sets outer
                walk_done_q <= walk_last;
                if (way_cnt_q == WAY_W'(N_WAYS - 1))
                    set_cnt_q <= set_cnt_q + 1'b1;
            end
        end
    end

    // Request and fill payload
    always_ff @(posedge clk_i)
    begin
        if ((state_q == IDLE) && p_strobe_i)
        begin
            req_addr_q <= p_addr_i;
            req_rw_q   <= p_rw_i;
            req_be_q   <= p_be_i;
            req_data_q <= p_data_i;
        end
        if ((state_q == FILL_REQ) && m_ready_i)
            fill_line_q <= m_data_i;
    end

    // ==============================
    // Memory request
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
            req_sent_q <= 1'b0;
        end
        else
        begin
            m_strobe_o <= launch;            // One-cycle pulse
            if (launch)
            begin
                m_rw_o     <= (state_q != FILL_REQ);
                req_sent_q <= 1'b1;
            end
            else if (m_ready_i)
                req_sent_q <= 1'b0;
        end
    end

    // Address and line held until ready
    always_ff @(posedge clk_i)
    begin
        if (launch)
        begin
            case (state_q)
                EVICT_REQ:
                begin
                    m_addr_o <= {victim_tag_i, req_idx, OFS_W'(0)};
                    m_data_o <= ram_rdata_i[victim_way_i];
                end
                FLUSH_REQ:
                begin
                    m_addr_o <= {way_tag_i, set_cnt_q, OFS_W'(0)};
                    m_data_o <= ram_rdata_i[way_cnt_q];
                end
                default:  m_addr_o <= {req_addr_q[XLEN-1:OFS_W], OFS_W'(0)};  // Line fill
            endcase
        end
    end

    // ==============================
    // Array side
    // ==============================
    always_comb
    begin
        case (state_q)
            IDLE:                  idx_o = p_addr_i[OFS_W +: IDX_W];
            FLUSH_REQ, FLUSH_DONE: idx_o = set_cnt_q;
            LOOKUP:                idx_o = busy_flushing_o ? set_cnt_q : req_idx;
            default:               idx_o = req_idx;
        endcase
    end

    assign way_o = (state_q == FLUSH_REQ) ? way_cnt_q :
                   (state_q == LOOKUP)    ? hit_way_i : victim_way_i;

    assign fill_o       = (state_q == FILL_DONE);
    assign mark_dirty_o = wr_hit || ((state_q == FILL_DONE) && req_rw_q);
    assign clean_o      = (state_q == FLUSH_REQ) && m_ready_i;   // Written back

    always_comb
    begin
        for (int w = 0; w < N_WAYS; w++)
        begin
            ram_we_o[w] = (wr_hit && (hit_way_i == WAY_W'(w))) ||
                          ((state_q == FILL_DONE) && (victim_way_i == WAY_W'(w)));
        end
    end

    // Raw fill on a read miss, merged line otherwise
    assign ram_wdata_o   = ((state_q == FILL_DONE) && !req_rw_q) ? fill_line_q : merge_line_i;
    assign merge_line_o  = (state_q == FILL_DONE) ? fill_line_q : ram_rdata_i[hit_way_i];
    assign merge_ofs_o   = req_addr_q[BYTE_OFS_W +: WORD_OFS_W];
    assign merge_be_o    = req_be_q;
    assign merge_wdata_o = req_data_q;

    assign p_data_o  = merge_word_i;    // Valid with p_ready_o on a read
    assign p_ready_o = ((state_q == LOOKUP) && !busy_flushing_o && hit_i) ||
                       (state_q == FILL_DONE) || ((state_q == FLUSH_DONE) && walk_done_q);

endmodule

// File: design/dcache_data_ram.sv
module dcache_data_ram #(
    parameter  int N_SETS = 16,
    localparam int IDX_W  = $clog2(N_SETS)
) (
    input  logic                   clk_i,
    input  logic                   we_i,
    input  logic [IDX_W-1:0]       idx_i,
    input  dcache_geom_pkg::line_t wdata_i,
    output dcache_geom_pkg::line_t rdata_o
);
    import dcache_geom_pkg::*;

    line_t mem [N_SETS];  // One line per set

    // Single port, read one cycle after the index
    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            mem[idx_i] <= wdata_i;
        end
        rdata_o <= mem[idx_i];  // Old line on a same-cycle write
    end

endmodule

// File: design/dcache_fsm_pkg.sv
package dcache_fsm_pkg;

    // Controller states
    typedef enum logic [3:0] {
        IDLE,        // Waiting for strobe or flush
        LOOKUP,      // Tags and lines read out, hit known
        EVICT_REQ,   // Dirty victim going to memory
        EVICT_DONE,
        FILL_REQ,    // Line read from memory
        FILL_DONE,   // Line written into the way
        FLUSH_REQ,   // One entry of the flush walk
        FLUSH_DONE   // Step to next entry
    } ctrl_state_t;

endpackage

// File: design/dcache_geom_pkg.sv
package dcache_geom_pkg;

    // ==============================
    // Word and line shape
    // ==============================
    localparam int XLEN           = 32;                     // Processor word
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = XLEN * WORDS_PER_LINE;  // 128 bit line
    localparam int BYTE_OFS_W     = 2;                      // Byte within word
    localparam int WORD_OFS_W     = 2;                      // Word within line

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [LINE_W-1:0] line_t;   // Word 0 in the top bits
    typedef logic [XLEN/8-1:0] be_t;     // One bit per byte lane
    typedef logic [XLEN-1:0]   addr_t;

    // Address split, low to high
    //   [1:0]  byte in word
    //   [3:2]  word in line
    //   then $clog2(N_SETS) bits of set index, the rest is tag

endpackage

// File: design/dcache_merge.sv
module dcache_merge (
    input  dcache_geom_pkg::line_t                 line_i,
    input  logic [dcache_geom_pkg::WORD_OFS_W-1:0] word_ofs_i,
    input  dcache_geom_pkg::be_t                   be_i,
    input  dcache_geom_pkg::word_t                 wdata_i,
    output dcache_geom_pkg::word_t                 word_o,
    output dcache_geom_pkg::line_t                 line_o
);
    import dcache_geom_pkg::*;

    word_t [WORDS_PER_LINE-1:0] words;    // Top slot holds word 0
    word_t [WORDS_PER_LINE-1:0] upd;
    logic  [WORD_OFS_W-1:0]     slot;
    word_t                      merged;

    assign words  = line_i;
    assign slot   = WORD_OFS_W'(WORDS_PER_LINE - 1) - word_ofs_i;  // Offset 0 is MSB
    assign word_o = words[slot];

    // Enabled byte lanes take processor data
    always_comb
    begin
        for (int b = 0; b < XLEN / 8; b++)
        begin
            merged[8*b +: 8] = be_i[b] ? wdata_i[8*b +: 8] : word_o[8*b +: 8];
        end
    end

    // Put the merged word back in place
    always_comb
    begin
        upd       = words;
        upd[slot] = merged;
    end

    assign line_o = upd;

endmodule

// File: design/dcache_meta.sv
module dcache_meta #(
    parameter  int N_WAYS = 4,
    parameter  int N_SETS = 16,
    localparam int WAY_W  = $clog2(N_WAYS),
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int TAG_W  = dcache_geom_pkg::XLEN - IDX_W
                            - dcache_geom_pkg::WORD_OFS_W - dcache_geom_pkg::BYTE_OFS_W
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [IDX_W-1:0] idx_i,
    input  logic [TAG_W-1:0] tag_i,
    input  logic             fill_i,          // Install tag at way_i
    input  logic             mark_dirty_i,
    input  logic             clean_i,
    input  logic [WAY_W-1:0] way_i,
    output logic             hit_o,
    output logic [WAY_W-1:0] hit_way_o,
    output logic [WAY_W-1:0] victim_way_o,
    output logic             victim_dirty_o,
    output logic [TAG_W-1:0] victim_tag_o,
    output logic [TAG_W-1:0] way_tag_o,       // Entry at way_i, for flush
    output logic             way_dirty_o
);

    logic [N_WAYS-1:0][TAG_W-1:0] tag_mem [N_SETS];  // Tag array
    logic [N_WAYS-1:0][TAG_W-1:0] rd_tags;           // All ways of one set
    logic [N_WAYS-1:0]            valid_q [N_SETS];
    logic [N_WAYS-1:0]            dirty_q [N_SETS];
    logic [WAY_W-1:0]             fifo_q  [N_SETS];  // Next way to replace
    logic [N_WAYS-1:0]            hit_vec;

    // ==============================
    // Tag store, synchronous read
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (fill_i)
        begin
            tag_mem[idx_i][way_i] <= tag_i;
        end
        rd_tags <= tag_mem[idx_i];
    end

    // Valid, dirty and FIFO pointer per set
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                fifo_q[s]  <= '0;
            end
        end
        else if (fill_i)
        begin
            valid_q[idx_i][way_i] <= 1'b1;
            dirty_q[idx_i][way_i] <= mark_dirty_i;            // Write miss lands dirty
            fifo_q[idx_i]         <= fifo_q[idx_i] + 1'b1;    // Wraps over the ways
        end
        else if (mark_dirty_i)
        begin
            dirty_q[idx_i][way_i] <= 1'b1;
        end
        else if (clean_i)
        begin
            dirty_q[idx_i][way_i] <= 1'b0;
        end
    end

    // ==============================
    // Hit detection
    // ==============================
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            hit_vec[w] = valid_q[idx_i][w] && (rd_tags[w] == tag_i);
            if (hit_vec[w])
            begin
                hit_way_o = WAY_W'(w);
            end
        end
    end

    assign hit_o = |hit_vec;

    assign victim_way_o   = fifo_q[idx_i];
    assign victim_dirty_o = dirty_q[idx_i][victim_way_o];
    assign victim_tag_o   = rd_tags[victim_way_o];   // For the write-back address
    assign way_tag_o      = rd_tags[way_i];
    assign way_dirty_o    = dirty_q[idx_i][way_i];

endmodule

// File: design/dcache_top.sv
module dcache_top #(
    parameter  int N_WAYS = 4,     // Power of two
    parameter  int N_SETS = 16,    // Power of two
    localparam int WAY_W  = $clog2(N_WAYS),
    localparam int IDX_W  = $clog2(N_SETS),
    localparam int TAG_W  = dcache_geom_pkg::XLEN - IDX_W
                            - dcache_geom_pkg::WORD_OFS_W - dcache_geom_pkg::BYTE_OFS_W
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   p_strobe_i,
    input  logic                   p_rw_i,
    input  dcache_geom_pkg::be_t   p_be_i,
    input  dcache_geom_pkg::addr_t p_addr_i,
    input  dcache_geom_pkg::word_t p_data_i,
    input  logic                   p_flush_i,
    output dcache_geom_pkg::word_t p_data_o,
    output logic                   p_ready_o,
    output logic                   busy_flushing_o,
    output logic                   m_strobe_o,
    output logic                   m_rw_o,
    output dcache_geom_pkg::addr_t m_addr_o,
    output dcache_geom_pkg::line_t m_data_o,
    input  logic                   m_ready_i,
    input  dcache_geom_pkg::line_t m_data_i
);
    import dcache_geom_pkg::*;

    logic [IDX_W-1:0]      idx;
    logic [TAG_W-1:0]      tag;
    logic [WAY_W-1:0]      way;
    logic                  fill;
    logic                  mark_dirty;
    logic                  clean;
    logic                  hit;
    logic [WAY_W-1:0]      hit_way;
    logic [WAY_W-1:0]      victim_way;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    logic [TAG_W-1:0]      way_tag;
    logic                  way_dirty;
    logic [N_WAYS-1:0]     ram_we;
    line_t                 ram_wdata;
    line_t                 ram_rdata [N_WAYS];
    word_t                 merge_word;
    line_t                 merge_line_in;     // Hit line or fill line
    line_t                 merge_line_out;
    logic [WORD_OFS_W-1:0] merge_ofs;
    be_t                   merge_be;
    word_t                 merge_wdata;

    // ==============================
    // Controller
    // ==============================
    dcache_ctrl #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) i_ctrl (
        .clk_i, .rst_i,
        .p_strobe_i, .p_rw_i, .p_be_i, .p_addr_i, .p_data_i, .p_flush_i,
        .p_data_o, .p_ready_o, .busy_flushing_o,
        .m_strobe_o, .m_rw_o, .m_addr_o, .m_data_o, .m_ready_i, .m_data_i,
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .way_tag_i      (way_tag),
        .way_dirty_i    (way_dirty),
        .idx_o          (idx),
        .tag_o          (tag),
        .way_o          (way),
        .fill_o         (fill),
        .mark_dirty_o   (mark_dirty),
        .clean_o        (clean),
        .ram_we_o       (ram_we),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata),
        .merge_word_i   (merge_word),
        .merge_line_i   (merge_line_out),
        .merge_line_o   (merge_line_in),
        .merge_ofs_o    (merge_ofs),
        .merge_be_o     (merge_be),
        .merge_wdata_o  (merge_wdata)
    );

    // Tags, valid, dirty, FIFO
    dcache_meta #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) i_meta (
        .clk_i, .rst_i,
        .idx_i          (idx),
        .tag_i          (tag),
        .fill_i         (fill),
        .mark_dirty_i   (mark_dirty),
        .clean_i        (clean),
        .way_i          (way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .way_tag_o      (way_tag),
        .way_dirty_o    (way_dirty)
    );

    dcache_merge i_merge (
        .line_i     (merge_line_in),
        .word_ofs_i (merge_ofs),
        .be_i       (merge_be),
        .wdata_i    (merge_wdata),
        .word_o     (merge_word),
        .line_o     (merge_line_out)
    );

    // One line RAM per way
    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        dcache_data_ram #(.N_SETS(N_SETS)) i_ram (
            .clk_i,
            .we_i    (ram_we[w]),
            .idx_i   (idx),
            .wdata_i (ram_wdata),
            .rdata_o (ram_rdata[w])
        );
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dcache 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: sim/dcache_checker.sv
module dcache_checker (
    input  logic         clk_i,
    input  logic         rst_i,
    input  int           test_id_i,
    input  logic [1:0]   expect_i,     // 0 none, 1 hit, 2 miss
    input  logic         p_strobe_i,
    input  logic         p_rw_i,
    input  logic [3:0]   p_be_i,
    input  logic [31:0]  p_addr_i,
    input  logic [31:0]  p_data_i,
    input  logic         p_flush_i,
    input  logic [31:0]  p_rdata_i,
    input  logic         p_ready_i,
    input  logic         busy_i,
    input  logic         m_strobe_i,
    input  logic         m_rw_i,
    input  logic [31:0]  m_addr_i,
    input  logic [127:0] m_wdata_i,
    output int           err_cnt_o,
    output int           check_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] EXP_HIT  = 2'd1;
    localparam logic [1:0] EXP_MISS = 2'd2;

    logic [31:0] shadow [0:16383];          // Word image of memory plus pending writes
    bit          dirty_lines [int unsigned]; // Lines written since their last write-back
    logic        req_pend;
    logic        flush_pend;
    logic        req_rw;
    logic [31:0] req_addr;
    logic [1:0]  req_exp;
    int          req_test;
    int          lat;
    logic        fill_seen;
    logic        same_line;
    logic        prev_valid;
    logic [27:0] prev_line;

    // ==============================
    // Reference model
    // ==============================
    function automatic logic [31:0] mem_pattern(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    endfunction

    // Enabled bytes come from the new word
    function automatic logic [31:0] apply_be(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  be);
        logic [31:0] res;
        for (int b = 0; b < 4; b++)
        begin
            res[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "fifo_fill";
            2:       return "fifo_hit";
            3:       return "flush";
            4:       return "post_flush";
            default: return "random";
        endcase
    endfunction

    task automatic value_error(input string what, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
        err_cnt_o++;
        $display("** Error [%s] %s: expected %h, actual %h",
                 test_name(req_test), what, exp_v, act_v);
    endtask

    task automatic plain_error(input string what);
        err_cnt_o++;
        $display("[%s] %s", test_name(req_test), what);
    endtask

    // Memory write must carry the shadow line and be owed
    task automatic check_writeback();
        logic [31:0] exp_w;
        logic [31:0] act_w;
        int unsigned key;
        key = m_addr_i >> 4;
        for (int w = 0; w < 4; w++)
        begin
            exp_w = shadow[{m_addr_i[15:4], 2'(w)}];
            act_w = m_wdata_i[127-32*w -: 32];   // Word 0 in the top bits
            check_cnt_o++;
            if (exp_w !== act_w)
                value_error($sformatf("write-back %h word %0d", m_addr_i, w), exp_w, act_w);
        end
        if (dirty_lines.exists(key))
            dirty_lines.delete(key);
        else
            plain_error($sformatf("memory write of line %h, which had no new data", m_addr_i));
    endtask

    // A line fill fetches the line of the pending access
    task automatic check_fill();
        logic [31:0] exp_a;
        exp_a = {req_addr[31:4], 4'h0};
        check_cnt_o++;
        if (!req_pend)
            plain_error($sformatf("line fill of %h with no access pending", m_addr_i));
        else if (m_addr_i !== exp_a)
            value_error("fill address", exp_a, m_addr_i);
        else
            fill_seen = 1'b1;
    endtask

    task automatic accept_req();
        req_pend  = 1'b1;
        req_rw    = p_rw_i;
        req_addr  = p_addr_i;
        req_exp   = expect_i;
        req_test  = test_id_i;
        lat       = 0;
        fill_seen = 1'b0;
        same_line = prev_valid && (prev_line == p_addr_i[31:4]);
        if (p_rw_i)
        begin
            shadow[p_addr_i[15:2]] = apply_be(shadow[p_addr_i[15:2]], p_data_i, p_be_i);
            dirty_lines[p_addr_i >> 4] = 1'b1;
        end
    endtask

    task automatic finish_req();
        if (!req_rw)
        begin
            check_cnt_o++;
            if (p_rdata_i !== shadow[req_addr[15:2]])
                value_error($sformatf("read %h", req_addr), shadow[req_addr[15:2]], p_rdata_i);
        end
        if (same_line || (req_exp == EXP_HIT))
        begin
            check_cnt_o++;
            if (lat != 1)
                value_error("hit latency", 128'd1, 128'(lat));
        end
        if ((req_exp == EXP_MISS) && !fill_seen)
            plain_error($sformatf("access to %h was expected to miss but fetched no line",
                                  req_addr));
        prev_line  = req_addr[31:4];
        prev_valid = 1'b1;
        req_pend   = 1'b0;
    endtask

    initial
    begin
        err_cnt_o   = 0;
        check_cnt_o = 0;
        req_pend    = 1'b0;
        flush_pend  = 1'b0;
        prev_valid  = 1'b0;
        req_test    = 0;
        for (int i = 0; i < 16384; i++)
            shadow[i] = mem_pattern(32'(i) << 2);
    end

    // ==============================
    // Sampling at mid-cycle
    // ==============================
    always @(negedge clk_i)
    begin
        if (rst_i)
        begin
            if ({p_ready_i, m_strobe_i, m_rw_i, busy_i} !== 4'b0000)
                plain_error("control output not low during reset");
        end
        else
        begin
            if (m_strobe_i && m_rw_i)
                check_writeback();
            if (m_strobe_i && !m_rw_i)
                check_fill();
            if (req_pend)
            begin
                lat++;
                if (p_ready_i)
                    finish_req();
            end
            else if (flush_pend)
            begin
                if (p_ready_i)
                begin
                    flush_pend = 1'b0;
                    if (busy_i)
                        plain_error("busy_flushing_o still high when the flush completed");
                    if (dirty_lines.num() != 0)
                        plain_error($sformatf("%0d modified lines left unwritten by flush",
                                              dirty_lines.num()));
                end
                else if (!busy_i)
                    plain_error("busy_flushing_o low while the flush is running");
            end
            if (p_strobe_i)
                accept_req();
            if (p_flush_i)
            begin
                flush_pend = 1'b1;
                req_test   = test_id_i;
            end
        end
    end

endmodule

// File: sim/tb_dcache.sv
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_WAYS  = 4;
    localparam int N_SETS  = 16;
    localparam int N_FIFO  = 7;
    localparam int N_RAND  = 400;
    localparam int N_POST  = 50;
    localparam int N_REQ   = N_FIFO + N_RAND + N_POST;
    localparam int TIMEOUT = 200 * N_REQ + 2000;   // Flush walk gets 2000

    localparam logic [1:0] EXP_NONE = 2'd0;
    localparam logic [1:0] EXP_HIT  = 2'd1;
    localparam logic [1:0] EXP_MISS = 2'd2;

    logic         clk;
    logic         rst;
    logic         p_strobe;
    logic         p_rw;
    logic [3:0]   p_be;
    logic [31:0]  p_addr;
    logic [31:0]  p_wdata;
    logic         p_flush;
    logic [31:0]  p_rdata;
    logic         p_ready;
    logic         busy_flushing;
    logic         m_strobe;
    logic         m_rw;
    logic [31:0]  m_addr;
    logic [127:0] m_wdata;
    logic         m_ready;
    logic [127:0] m_rdata;
    int           test_id;
    logic [1:0]   exp_kind;
    int           err_cnt;
    int           check_cnt;
    int           cycles;
    logic [31:0]  rnd_state = 32'h1023_25ad;
    logic [31:0]  mem [0:16383];                  // Backing store with one word per entry
    logic [3:0]   be_pat [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                 4'b0011, 4'b1100, 4'b1111};

    dcache_top #(.N_WAYS(N_WAYS), .N_SETS(N_SETS)) i_dut (
        .clk_i (clk), .rst_i (rst),
        .p_strobe_i (p_strobe), .p_rw_i (p_rw), .p_be_i (p_be), .p_addr_i (p_addr),
        .p_data_i (p_wdata), .p_flush_i (p_flush),
        .p_data_o (p_rdata), .p_ready_o (p_ready), .busy_flushing_o (busy_flushing),
        .m_strobe_o (m_strobe), .m_rw_o (m_rw), .m_addr_o (m_addr), .m_data_o (m_wdata),
        .m_ready_i (m_ready), .m_data_i (m_rdata)
    );

    dcache_checker i_checker (
        .clk_i (clk), .rst_i (rst), .test_id_i (test_id), .expect_i (exp_kind),
        .p_strobe_i (p_strobe), .p_rw_i (p_rw), .p_be_i (p_be), .p_addr_i (p_addr),
        .p_data_i (p_wdata), .p_flush_i (p_flush),
        .p_rdata_i (p_rdata), .p_ready_i (p_ready), .busy_i (busy_flushing),
        .m_strobe_i (m_strobe), .m_rw_i (m_rw), .m_addr_i (m_addr), .m_wdata_i (m_wdata),
        .err_cnt_o (err_cnt), .check_cnt_o (check_cnt)
    );

    function automatic logic [31:0] next_rand();
        rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
        return rnd_state >> 8;   // Low bits are weak
    endfunction

    function automatic logic [31:0] mem_pattern(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial
    begin
        cycles = 0;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > TIMEOUT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("test failed");
            $finish;
        end
    end

    // ==============================
    // Memory model
    // ==============================
    initial
    begin
        int          delay;
        logic [31:0] a;
        logic [127:0] line;
        m_ready = 1'b0;
        m_rdata = '0;
        for (int i = 0; i < 16384; i++)
            mem[i] = mem_pattern(32'(i) << 2);
        forever
        begin
            @(negedge clk);
            if (!rst && m_strobe)
            begin
                a = m_addr;
                for (int w = 0; w < 4; w++)
                begin
                    if (m_rw)
                        mem[{a[15:4], 2'(w)}] = m_wdata[127-32*w -: 32];
                    line[127-32*w -: 32] = mem[{a[15:4], 2'(w)}];   // Word 0 on top
                end
                delay = 2 + int'(next_rand() % 32'd4);
                repeat (delay) @(posedge clk);
                #1;
                m_ready = 1'b1;
                m_rdata = line;
                @(posedge clk);
                #1;
                m_ready = 1'b0;
            end
        end
    end

    // One request and its wait for ready
    task automatic access(input logic rw, input logic [31:0] addr, input logic [3:0] be,
                          input logic [31:0] data, input logic [1:0] kind);
        @(posedge clk);
        #1;
        p_strobe = 1'b1;
        p_rw     = rw;
        p_addr   = addr;
        p_be     = be;
        p_wdata  = data;
        exp_kind = kind;
        @(posedge clk);
        #1;
        p_strobe = 1'b0;
        do
            @(negedge clk);
        while (!p_ready);
    endtask

    task automatic random_access(input logic allow_write);
        logic [31:0] tag;
        logic [31:0] set;
        logic [31:0] word;
        logic [31:0] coin;
        logic [3:0]  be;
        logic [31:0] data;
        logic        rw;
        tag  = next_rand() % 32'd12;
        set  = next_rand() % 32'd4;
        word = next_rand() % 32'd4;
        coin = next_rand();
        rw   = allow_write && coin[0];
        be   = be_pat[3'(next_rand() % 32'd7)];
        data = next_rand();
        data = data ^ (next_rand() << 12);
        access(rw, (tag << 8) | (set << 4) | (word << 2), be, data, EXP_NONE);
    endtask

    task automatic flush_cache();
        @(posedge clk);
        #1;
        p_flush = 1'b1;
        @(posedge clk);
        #1;
        p_flush = 1'b0;
        do
            @(negedge clk);
        while (!p_ready);
    endtask

    function automatic logic [31:0] set9_addr(input int tag);
        return (32'(tag) << 8) | (32'd9 << 4);   // Set 9 stays out of the random range
    endfunction

    initial
    begin
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_be     = '0;
        p_addr   = '0;
        p_wdata  = '0;
        p_flush  = 1'b0;
        test_id  = 0;
        exp_kind = EXP_NONE;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // A to D fill the four ways in order and E evicts A
        test_id = 1;
        for (int t = 0; t < 5; t++)
            access(1'b0, set9_addr(100 + t), 4'hf, '0, EXP_MISS);
        test_id = 2;
        access(1'b0, set9_addr(101), 4'hf, '0, EXP_HIT);
        access(1'b0, set9_addr(100), 4'hf, '0, EXP_MISS);

        test_id = 0;
        for (int i = 0; i < N_RAND; i++)
            random_access(1'b1);

        test_id = 3;
        flush_cache();

        test_id = 4;
        for (int i = 0; i < N_POST; i++)
            random_access(1'b0);

        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
